// ==== list.f ====
+incdir+src
src/if_bus_pkg.sv
src/if_ctrl_pkg.sv
src/fetch_fifo.sv
src/prefetch_buffer.sv
src/if_stage.sv
tests/instr_mem_model.sv
tests/tb_if_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end regression with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_if_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_if_stage 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// ==== src/fetch_fifo.sv ====
/* synchronous fifo with flush */

`include "fetch_macros.svh"

module fetch_fifo #(
  parameter type         payload_t = if_bus_pkg::instr_t,
  parameter int unsigned DEPTH     = `FETCH_FIFO_DEPTH  // power of two
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,      // drop all entries
  input  logic                    push_i,
  input  payload_t                push_data_i,
  input  logic                    pop_i,
  output payload_t                pop_data_o,   // head entry, valid when !empty_o
  output logic                    empty_o,
  output logic                    full_o,
  output logic [`FETCH_CNT_W-1:0] count_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  payload_t                mem_q [DEPTH];   // storage, no reset
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [`FETCH_CNT_W-1:0] count_q;
  logic                    do_push;
  logic                    do_pop;

  assign do_push = push_i & ~full_o;   // push into a full fifo is ignored
  assign do_pop  = pop_i & ~empty_o;

  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == `FETCH_CNT_W'(DEPTH));
  assign count_o    = count_q;
  assign pop_data_o = mem_q[rd_ptr_q];

  ////////////////////
  // pointers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin   // flush wins over push and pop
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // idle or push+pop
      endcase
    end
  end

  // data array
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== src/fetch_macros.svh ====
/* fetch front end widths */

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// bus and datapath widths
`define FETCH_ADDR_W      32
`define FETCH_WORD_BYTES  4     // sequential fetch stride

// prefetch storage
`define FETCH_FIFO_DEPTH  4     // words buffered ahead of decode
`define FETCH_CNT_W       3     // holds 0 .. FETCH_FIFO_DEPTH

// trap vector layout
`define TRAP_BASE_W       24    // upper bits of the trap base
`define TRAP_OFFSET_W     8     // zero bits below the base for exceptions

`endif

// ==== src/if_bus_pkg.sv ====
/* fetch bus types */

`include "fetch_macros.svh"

package if_bus_pkg;

  // byte address on the instruction port and in the pipeline
  typedef logic [`FETCH_ADDR_W-1:0] addr_t;

  // one 32 bit instruction word, always word aligned
  typedef logic [31:0] instr_t;

endpackage

// ==== src/if_ctrl_pkg.sv ====
/* fetch control selects */

package if_ctrl_pkg;

  ////////////////////
  // next pc source
  ////////////////////

  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000,  // reset / boot address
    PC_FENCEI    = 4'b0001,  // refetch after fence.i
    PC_JUMP      = 4'b0010,  // jump resolved in decode
    PC_BRANCH    = 4'b0011,  // branch resolved in execute
    PC_EXCEPTION = 4'b0100,  // trap entry, see exc_pc_mux_e
    PC_MRET      = 4'b0101,  // return from machine trap
    PC_DRET      = 4'b0111   // return from debug mode
  } pc_mux_e;

  ////////////////////
  // trap target kind
  ////////////////////

  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,  // synchronous exception, base only
    EXC_PC_IRQ       = 2'b01,  // vectored interrupt
    EXC_PC_DBD       = 2'b10   // debug halt entry
  } exc_pc_mux_e;

  // fetch fsm: idle until the first request, then streaming
  typedef enum logic {
    FETCH_IDLE = 1'b0,
    FETCH_WAIT = 1'b1
  } fetch_state_e;

endpackage

// ==== src/if_stage.sv ====
/* instruction fetch stage */

`include "fetch_macros.svh"

module if_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_i,
  input  if_bus_pkg::addr_t         boot_addr_i,
  input  logic [`TRAP_BASE_W-1:0]   trap_base_addr_i,
  input  logic [4:0]                exc_vec_pc_mux_i,   // interrupt vector number
  input  if_bus_pkg::addr_t         dm_halt_addr_i,
  input  if_bus_pkg::addr_t         mepc_i,
  input  if_bus_pkg::addr_t         depc_i,
  input  if_bus_pkg::addr_t         pc_i,               // pc of the fence.i
  input  if_bus_pkg::addr_t         jump_target_id_i,
  input  if_bus_pkg::addr_t         jump_target_ex_i,
  input  logic                      pc_set_i,
  input  if_ctrl_pkg::pc_mux_e      pc_mux_i,
  input  if_ctrl_pkg::exc_pc_mux_e  exc_pc_mux_i,
  input  logic                      clear_instr_valid_i,
  input  logic                      halt_if_i,
  input  logic                      id_ready_i,
  // instruction port
  output logic                      instr_req_o,
  output if_bus_pkg::addr_t         instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  if_bus_pkg::instr_t        instr_rdata_i,
  // to decode
  output logic                      instr_valid_id_o,
  output if_bus_pkg::instr_t        instr_rdata_id_o,
  output if_bus_pkg::addr_t         instr_addr_id_o,
  output if_bus_pkg::addr_t         branch_target_o,
  output logic                      csr_mtvec_init_o,
  output logic                      if_busy_o
);

  if_ctrl_pkg::fetch_state_e fsm_q;
  if_ctrl_pkg::fetch_state_e fsm_d;

  if_bus_pkg::addr_t  exc_pc;
  if_bus_pkg::addr_t  branch_addr_n;
  logic               branch_req;
  logic               valid;          // buffer word may go to decode
  logic               if_valid;       // word moves into IF/ID this cycle
  logic               fetch_valid;
  if_bus_pkg::instr_t fetch_rdata;
  if_bus_pkg::addr_t  fetch_addr;
  logic               prefetch_busy;

  ////////////////////
  // target selection
  ////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      if_ctrl_pkg::EXC_PC_EXCEPTION: exc_pc = {trap_base_addr_i, `TRAP_OFFSET_W'(0)};
      if_ctrl_pkg::EXC_PC_IRQ:       exc_pc = {trap_base_addr_i, 1'b0, exc_vec_pc_mux_i, 2'b00};
      if_ctrl_pkg::EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
      default:                       exc_pc = {trap_base_addr_i, `TRAP_OFFSET_W'(0)};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      if_ctrl_pkg::PC_BOOT:      branch_addr_n = {boot_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
      if_ctrl_pkg::PC_JUMP:      branch_addr_n = jump_target_id_i;
      if_ctrl_pkg::PC_BRANCH:    branch_addr_n = jump_target_ex_i;
      if_ctrl_pkg::PC_EXCEPTION: branch_addr_n = exc_pc;
      if_ctrl_pkg::PC_MRET:      branch_addr_n = mepc_i;   // back to the trapped pc
      if_ctrl_pkg::PC_DRET:      branch_addr_n = depc_i;
      if_ctrl_pkg::PC_FENCEI:    branch_addr_n = pc_i + `FETCH_ADDR_W'(`FETCH_WORD_BYTES);
      default:                   branch_addr_n = '0;
    endcase
  end

  assign branch_target_o  = branch_addr_n;
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_ctrl_pkg::PC_BOOT);   // boot cycle only

  prefetch_buffer u_prefetch_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_req),
    .branch_addr_i  (branch_addr_n),
    .fetch_ready_i  (if_valid),      // pop exactly what IF/ID takes
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_addr_o   (fetch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (prefetch_busy)
  );

  ////////////////////
  // fetch fsm
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fsm_q <= if_ctrl_pkg::FETCH_IDLE;
    end else begin
      fsm_q <= fsm_d;
    end
  end

  always_comb begin
    fsm_d      = fsm_q;
    branch_req = 1'b0;
    valid      = 1'b0;

    unique case (fsm_q)
      if_ctrl_pkg::FETCH_IDLE: begin
        if (req_i) begin            // first fetch starts at the selected pc
          branch_req = 1'b1;
          fsm_d      = if_ctrl_pkg::FETCH_WAIT;
        end
      end
      if_ctrl_pkg::FETCH_WAIT: begin
        valid = fetch_valid;
      end
      default: fsm_d = if_ctrl_pkg::FETCH_IDLE;
    endcase

    // a redirect kills the word on offer and restarts the buffer
    if (pc_set_i) begin
      valid      = 1'b0;
      branch_req = 1'b1;
      fsm_d      = if_ctrl_pkg::FETCH_WAIT;
    end
  end

  assign if_valid  = valid & id_ready_i & ~halt_if_i;
  assign if_busy_o = prefetch_busy;

  ////////////////////
  // IF/ID registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (if_valid) begin
      instr_valid_id_o <= 1'b1;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o <= 1'b0;    // decode consumed it, nothing new
    end
  end

  // word and pc freeze while decode stalls
  always_ff @(posedge clk) begin
    if (if_valid) begin
      instr_rdata_id_o <= fetch_rdata;
      instr_addr_id_o  <= fetch_addr;
    end
  end

endmodule

// ==== src/prefetch_buffer.sv ====
/* prefetch buffer */

`include "fetch_macros.svh"

module prefetch_buffer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_i,           // fetching enabled
  input  logic               branch_i,        // redirect, flushes the buffer
  input  if_bus_pkg::addr_t  branch_addr_i,
  input  logic               fetch_ready_i,
  output logic               fetch_valid_o,
  output if_bus_pkg::instr_t fetch_rdata_o,
  output if_bus_pkg::addr_t  fetch_addr_o,
  output logic               instr_req_o,
  output if_bus_pkg::addr_t  instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  if_bus_pkg::instr_t instr_rdata_i,
  output logic               busy_o
);

  localparam logic [`FETCH_CNT_W:0] DEPTH_C = `FETCH_FIFO_DEPTH;

  logic                    active_q;      // set by the first redirect
  logic                    hold_q;        // request shown last cycle, no grant yet
  logic                    redir_q;       // redirect waiting behind a held request
  if_bus_pkg::addr_t       addr_q;        // address on the bus / next to request
  if_bus_pkg::addr_t       tgt_q;         // parked redirect target
  if_bus_pkg::addr_t       target;
  logic [`FETCH_CNT_W-1:0] out_q;         // granted, not yet answered
  logic [`FETCH_CNT_W-1:0] out_d;
  logic [`FETCH_CNT_W-1:0] discard_q;     // stale responses still to come
  logic [`FETCH_CNT_W-1:0] discard_d;
  logic [`FETCH_CNT_W-1:0] data_count;
  logic [`FETCH_CNT_W:0]   credit_sum;
  logic                    credit_ok;
  logic                    gnt_fire;
  logic                    stale_gnt;
  logic                    drop_rsp;
  logic                    keep_rsp;
  logic                    data_empty;
  logic                    pop;

  assign target = {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};   // word aligned

  ////////////////////
  // request side
  ////////////////////

  // credit: in flight plus buffered never exceeds the fifo depth
  assign credit_sum = {1'b0, out_q} + {1'b0, data_count};
  assign credit_ok  = (credit_sum < DEPTH_C);

  // a held request stays up until granted, whatever else happens
  assign instr_req_o  = hold_q | (active_q & req_i & credit_ok & ~branch_i);
  assign instr_addr_o = addr_q;
  assign gnt_fire     = instr_req_o & instr_gnt_i;
  assign stale_gnt    = gnt_fire & (branch_i | redir_q);   // old stream, answer is dropped

  ////////////////////
  // response side
  ////////////////////

  assign drop_rsp = instr_rvalid_i & (branch_i | (discard_q != '0));
  assign keep_rsp = instr_rvalid_i & ~drop_rsp;

  assign out_d = out_q + `FETCH_CNT_W'(gnt_fire) - `FETCH_CNT_W'(instr_rvalid_i);

  always_comb begin
    discard_d = discard_q;
    if (branch_i) begin
      // every unanswered grant is now stale, including one in this cycle
      discard_d = out_q - `FETCH_CNT_W'(instr_rvalid_i) + `FETCH_CNT_W'(gnt_fire);
    end else begin
      if (drop_rsp) begin
        discard_d = discard_d - 1'b1;
      end
      if (stale_gnt) begin
        discard_d = discard_d + 1'b1;   // late grant of a request held over a redirect
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      hold_q    <= 1'b0;
      redir_q   <= 1'b0;
      addr_q    <= '0;
      out_q     <= '0;
      discard_q <= '0;
    end else begin
      hold_q    <= instr_req_o & ~instr_gnt_i;
      out_q     <= out_d;
      discard_q <= discard_d;
      if (branch_i) begin
        active_q <= 1'b1;
        if (hold_q & ~instr_gnt_i) begin
          redir_q <= 1'b1;             // finish the held request first
        end else begin
          addr_q  <= target;           // target goes out next cycle
          redir_q <= 1'b0;
        end
      end else if (gnt_fire) begin
        if (redir_q) begin
          addr_q  <= tgt_q;
          redir_q <= 1'b0;
        end else begin
          addr_q <= addr_q + `FETCH_ADDR_W'(`FETCH_WORD_BYTES);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (branch_i) begin
      tgt_q <= target;
    end
  end

  ////////////////////
  // word and address queues
  ////////////////////

  assign fetch_valid_o = ~data_empty & ~branch_i;   // flush is visible at once
  assign pop           = fetch_valid_o & fetch_ready_i;

  fetch_fifo #(
    .payload_t   (if_bus_pkg::instr_t),
    .DEPTH       (`FETCH_FIFO_DEPTH)
  ) data_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (keep_rsp),
    .push_data_i (instr_rdata_i),
    .pop_i       (pop),
    .pop_data_o  (fetch_rdata_o),
    .empty_o     (data_empty),
    .full_o      (),
    .count_o     (data_count)
  );

  // one address per live grant, head pairs with the data head
  fetch_fifo #(
    .payload_t   (if_bus_pkg::addr_t),
    .DEPTH       (`FETCH_FIFO_DEPTH)
  ) addr_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (gnt_fire & ~stale_gnt),
    .push_data_i (instr_addr_o),
    .pop_i       (pop),
    .pop_data_o  (fetch_addr_o),
    .empty_o     (),
    .full_o      (),
    .count_o     ()
  );

  assign busy_o = (out_q != '0) | instr_req_o;

endmodule

// ==== tests/fetch_cases.txt ====
# name pc_mux exc_pc_mux operand vector words stall_pct
# operand feeds the selected source, vector is the irq number
boot        0 0 00001082 00 12  0
jump        2 0 00002000 00  8 25
branch      3 0 00003a40 00  8 40
mret        5 0 00004010 00  6  0
dret        7 0 00005ffc 00  6 30
fencei      1 0 00006100 00  6  0
exception   4 0 00000123 00  6 20
irq_vector  4 1 00000123 0b  6 20
debug_halt  4 2 00008802 00  6 10
stall_heavy 2 0 0000a000 00 16 60
jump_back   2 0 00001080 00  8 50

// ==== tests/instr_mem_model.sv ====
/* instruction port responder */

module instr_mem_model (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_i,
  input  if_bus_pkg::addr_t  addr_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output if_bus_pkg::instr_t rdata_o
);

  logic [31:0]       rand_state = 32'hce0f_d1b3;
  if_bus_pkg::addr_t pend_q [$];     // granted, response still owed
  int                gnt_wait;       // cycles before the next grant
  int                rsp_wait;       // cycles before the next response
  logic              fire_gnt;
  logic              fire_rsp;
  logic              req_seen;
  if_bus_pkg::addr_t addr_seen;

  // lcg, two bits give a 0..3 cycle delay
  function automatic int next_delay();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return int'(rand_state[17:16]);
  endfunction

  // word at byte address a, addi opcode in the low bits
  function automatic if_bus_pkg::instr_t word_at(input if_bus_pkg::addr_t a);
    return (a ^ 32'h5a5a_0000) + 32'h13;
  endfunction

  // bus settles mid cycle
  always @(negedge clk) begin
    fire_gnt  = rst_n & req_i & gnt_o;
    fire_rsp  = rst_n & rvalid_o;
    req_seen  = rst_n & req_i;
    addr_seen = addr_i;
  end

  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      pend_q.delete();
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      gnt_wait = 0;
      rsp_wait = 0;
    end else begin
      if (fire_rsp) begin
        void'(pend_q.pop_front());   // answered last cycle
      end
      if (fire_gnt) begin
        pend_q.push_back(addr_seen);
        gnt_wait = next_delay();
      end else if (req_seen && gnt_wait > 0) begin
        gnt_wait = gnt_wait - 1;
      end
      gnt_o    = (gnt_wait == 0);
      rvalid_o = 1'b0;
      if (pend_q.size() != 0) begin
        if (rsp_wait > 0) begin
          rsp_wait = rsp_wait - 1;
        end else begin
          rvalid_o = 1'b1;             // in order, oldest grant first
          rdata_o  = word_at(pend_q[0]);
          rsp_wait = next_delay();
        end
      end
    end
  end

endmodule

// ==== tests/tb_if_stage.sv ====
/* fetch stage testbench */

module tb_if_stage;

  localparam int MAX_CASES = 32;

  logic clk = 1'b0;
  logic rst_n;
  logic req, pc_set, clear_valid, halt_if, id_ready;
  logic [31:0] boot_addr, dm_halt_addr, mepc, depc, pc, jump_target_id, jump_target_ex;
  logic [23:0] trap_base;
  logic [4:0]  exc_vec;
  if_ctrl_pkg::pc_mux_e     pc_mux;
  if_ctrl_pkg::exc_pc_mux_e exc_pc_mux;
  logic        instr_req, instr_gnt, instr_rvalid;
  logic [31:0] instr_addr, instr_rdata;
  logic        instr_valid_id, mtvec_init, if_busy;
  logic [31:0] instr_rdata_id, instr_addr_id, branch_target;

  // case table with one row per line of the case file
  logic [127:0] case_name [MAX_CASES];
  logic [31:0]  case_mux [MAX_CASES];
  logic [31:0]  case_exc [MAX_CASES];
  logic [31:0]  case_opa [MAX_CASES];
  logic [31:0]  case_opb [MAX_CASES];
  int           case_words [MAX_CASES];
  int           case_stall [MAX_CASES];
  int           num_cases;

  logic [127:0] cur_name;               // shown in error lines
  logic [31:0]  rand_state = 32'hce0f_d1b3;
  int           cycle_limit = 0;
  int           cycles = 0;
  logic         hold_seen = 1'b0;       // request without grant at last negedge
  logic [31:0]  hold_addr = '0;

  always #5 clk = ~clk;

  if_stage DUT (
    .clk(clk), .rst_n(rst_n), .req_i(req), .boot_addr_i(boot_addr),
    .trap_base_addr_i(trap_base), .exc_vec_pc_mux_i(exc_vec), .dm_halt_addr_i(dm_halt_addr),
    .mepc_i(mepc), .depc_i(depc), .pc_i(pc), .jump_target_id_i(jump_target_id),
    .jump_target_ex_i(jump_target_ex), .pc_set_i(pc_set), .pc_mux_i(pc_mux),
    .exc_pc_mux_i(exc_pc_mux), .clear_instr_valid_i(clear_valid), .halt_if_i(halt_if),
    .id_ready_i(id_ready), .instr_req_o(instr_req), .instr_addr_o(instr_addr),
    .instr_gnt_i(instr_gnt), .instr_rvalid_i(instr_rvalid), .instr_rdata_i(instr_rdata),
    .instr_valid_id_o(instr_valid_id), .instr_rdata_id_o(instr_rdata_id),
    .instr_addr_id_o(instr_addr_id), .branch_target_o(branch_target),
    .csr_mtvec_init_o(mtvec_init), .if_busy_o(if_busy)
  );

  instr_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(instr_req), .addr_i(instr_addr),
    .gnt_o(instr_gnt), .rvalid_o(instr_rvalid), .rdata_o(instr_rdata)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] a);
    return (a ^ 32'h5a5a_0000) + 32'h13;
  endfunction

  // next pc by source with trap kinds per base / vector / halt layout
  function automatic logic [31:0] rule_target(input int i);
    logic [31:0] opa;
    opa = case_opa[i];
    case (case_mux[i][3:0])
      if_ctrl_pkg::PC_BOOT:   return {opa[31:2], 2'b00};
      if_ctrl_pkg::PC_FENCEI: return opa + 32'h4;
      if_ctrl_pkg::PC_EXCEPTION: begin
        if (case_exc[i][1:0] == if_ctrl_pkg::EXC_PC_IRQ) begin
          return {opa[23:0], 1'b0, case_opb[i][4:0], 2'b00};
        end else if (case_exc[i][1:0] == if_ctrl_pkg::EXC_PC_DBD) begin
          return {opa[31:2], 2'b00};
        end
        return {opa[23:0], 8'h00};
      end
      default: return opa;                 // jump, branch, mret, dret
    endcase
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %0s %0s: expected %h, actual %h", cur_name, what, exp, act);
      $display("Regression failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  ////////////////////
  // case file
  ////////////////////

  task automatic read_cases();
    int fd;
    int n;
    int total;
    logic [8*128-1:0] line_buf;
    logic [127:0] f_name;
    logic [31:0] f_mux, f_exc, f_opa, f_opb;
    int f_words, f_stall;
    fd = $fopen("tests/fetch_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file tests/fetch_cases.txt");
      $display("Regression failed");
      $fatal(1, "no cases");
    end
    num_cases = 0;
    total = 0;
    while (!$feof(fd) && num_cases < MAX_CASES) begin
      line_buf = '0;
      void'($fgets(line_buf, fd));
      n = $sscanf(line_buf, "%s %h %h %h %h %d %d",
                  f_name, f_mux, f_exc, f_opa, f_opb, f_words, f_stall);
      if (n == 7) begin                    // comment and blank lines fall out here
        case_name[num_cases]  = f_name;
        case_mux[num_cases]   = f_mux;
        case_exc[num_cases]   = f_exc;
        case_opa[num_cases]   = f_opa;
        case_opb[num_cases]   = f_opb;
        case_words[num_cases] = f_words;
        case_stall[num_cases] = f_stall;
        total = total + f_words;
        num_cases = num_cases + 1;
      end
    end
    $fclose(fd);
    if (num_cases == 0) begin
      $display("the case file holds no valid case lines");
      $display("Regression failed");
      $fatal(1, "no cases");
    end
    cycle_limit = total * 20 + 200;
  endtask

  // decoys on every source while the selected one carries the operand
  task automatic drive_sources(input int i);
    boot_addr      = 32'h0000_0f04;
    jump_target_id = 32'h0000_0e00;
    jump_target_ex = 32'h0000_0d00;
    mepc           = 32'h0000_0c00;
    depc           = 32'h0000_0b00;
    pc             = 32'h0000_0a00;
    dm_halt_addr   = 32'h0000_0900;
    trap_base      = 24'h00_0080;
    exc_vec        = 5'h1f;
    pc_mux         = if_ctrl_pkg::pc_mux_e'(case_mux[i][3:0]);
    exc_pc_mux     = if_ctrl_pkg::exc_pc_mux_e'(case_exc[i][1:0]);
    case (case_mux[i][3:0])
      if_ctrl_pkg::PC_BOOT:   boot_addr = case_opa[i];
      if_ctrl_pkg::PC_JUMP:   jump_target_id = case_opa[i];
      if_ctrl_pkg::PC_BRANCH: jump_target_ex = case_opa[i];
      if_ctrl_pkg::PC_MRET:   mepc = case_opa[i];
      if_ctrl_pkg::PC_DRET:   depc = case_opa[i];
      if_ctrl_pkg::PC_FENCEI: pc = case_opa[i];
      if_ctrl_pkg::PC_EXCEPTION: begin
        dm_halt_addr = case_opa[i];
        trap_base    = case_opa[i][23:0];
        if (case_exc[i][1:0] == if_ctrl_pkg::EXC_PC_IRQ) begin
          exc_vec = case_opb[i][4:0];      // vector number only for interrupts
        end
      end
      default: ;
    endcase
  endtask

  ////////////////////
  // one redirect and its stream
  ////////////////////

  task automatic run_case(input int i);
    logic [31:0] exp_addr;
    logic [31:0] held_addr;
    logic [31:0] held_data;
    logic [31:0] rnd;
    logic        held_valid;
    logic        stall;
    logic        go;
    int          got;
    cur_name = case_name[i];
    drive_sources(i);
    req         = 1'b1;
    pc_set      = 1'b1;
    id_ready    = 1'b1;
    halt_if     = 1'b0;
    clear_valid = 1'b1;
    #2;                                     // combinational target settles
    check_eq("branch target", rule_target(i), branch_target);
    check_eq("mtvec init", 32'(case_mux[i][3:0] == if_ctrl_pkg::PC_BOOT), 32'(mtvec_init));
    @(posedge clk);
    #1;
    check_eq("valid after redirect", 32'h0, 32'(instr_valid_id));   // clear with no word
    pc_set   = 1'b0;
    exp_addr = rule_target(i) & 32'hffff_fffc;
    got      = 0;
    while (got < case_words[i]) begin
      rnd         = next_rand();
      stall       = ((rnd >> 16) % 32'd100) < 32'(case_stall[i]);
      halt_if     = stall & rnd[12];
      id_ready    = ~(stall & ~rnd[12]);
      go          = id_ready & ~halt_if;
      clear_valid = go;                     // decode takes what it holds
      held_valid  = instr_valid_id;
      held_addr   = instr_addr_id;
      held_data   = instr_rdata_id;
      @(posedge clk);
      #1;
      check_eq("mtvec init low", 32'h0, 32'(mtvec_init));
      if (!go) begin                        // IF/ID frozen
        check_eq("held valid", 32'(held_valid), 32'(instr_valid_id));
        check_eq("held address", held_addr, instr_addr_id);
        check_eq("held data", held_data, instr_rdata_id);
      end else if (instr_valid_id) begin
        check_eq("fetch address", exp_addr, instr_addr_id);
        check_eq("fetch data", expected_word(exp_addr), instr_rdata_id);
        exp_addr = exp_addr + 32'h4;
        got      = got + 1;
      end
    end
  endtask

  // request alignment and hold until grant
  always @(negedge clk) begin
    if (rst_n) begin
      if (instr_req) begin
        check_eq("request alignment", 32'h0, 32'(instr_addr[1:0]));
        check_eq("busy with request", 32'h1, 32'(if_busy));
      end
      if (hold_seen) begin
        check_eq("request held", 32'h1, 32'(instr_req));
        check_eq("held request address", hold_addr, instr_addr);
      end
    end
    hold_seen = rst_n & instr_req & ~instr_gnt;
    hold_addr = instr_addr;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: the stream did not complete within %0d cycles", cycle_limit);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    pc_set = 1'b0;
    clear_valid = 1'b0;
    halt_if = 1'b0;
    id_ready = 1'b0;
    boot_addr = '0;
    dm_halt_addr = '0;
    mepc = '0;
    depc = '0;
    pc = '0;
    jump_target_id = '0;
    jump_target_ex = '0;
    trap_base = '0;
    exc_vec = '0;
    pc_mux = if_ctrl_pkg::PC_BOOT;
    exc_pc_mux = if_ctrl_pkg::EXC_PC_EXCEPTION;
    cur_name = "reset";
    read_cases();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_eq("req after reset", 32'h0, 32'(instr_req));
    check_eq("valid after reset", 32'h0, 32'(instr_valid_id));
    check_eq("mtvec after reset", 32'h0, 32'(mtvec_init));
    check_eq("busy after reset", 32'h0, 32'(if_busy));
    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
    end
    $display("Regression passed");
    $finish;
  end

endmodule
